/* dv/exec_sva.sv */
`timescale 1ns/1ps

module exec_sva (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input logic out_valid,
    input logic rd_we,
    input logic br_taken,
    input logic illegal
);

    // decode reg then writeback reg, so exactly two edges
    a_latency: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> ##2 out_valid)
        else $error("out_valid missing two cycles after instr_valid");

    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(instr_valid, 2))
        else $error("out_valid without an instruction two cycles earlier");

    // qualified strobes
    a_qualified: assert property (@(posedge clk) disable iff (rst)
        (rd_we || br_taken) |-> out_valid)
        else $error("rd_we or br_taken high while out_valid low");

    // sync reset, so outputs settle one edge into reset
    a_reset_quiet: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !(out_valid || rd_we || br_taken || illegal))
        else $error("output active during reset");

endmodule

bind exec_top exec_sva u_sva (.*);

/* dv/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb;

    typedef struct packed {
        logic [exec_pkg::XLEN-1:0] data;    // rd value
        logic [exec_pkg::XLEN-1:0] target;
        logic [4:0]                rd;
        logic                      we;
        logic                      taken;
        logic                      illegal;
    } exp_t;

    logic                      clk = 1'b0;
    logic                      rst, instr_valid;
    logic [31:0]               instr;
    logic [exec_pkg::XLEN-1:0] pc, rs1_data, rs2_data;
    logic                      out_valid, rd_we, br_taken, illegal;
    logic [4:0]                rd_addr;
    logic [exec_pkg::XLEN-1:0] rd_data, br_target;

    exp_t  exp_q[$];    // in-flight expectations, oldest first
    string name_q[$];
    int    checks = 0;
    int    errors = 0;

    always #4 clk = ~clk;  // 8 ns period

    exec_top DUT (.*);

    task automatic check_data(input string name, input logic [exec_pkg::XLEN-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [4:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected x%0d, actual x%0d", name, exp, act);
        end
    endtask

    // rv32i alu rules, alt is funct7[5]
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, y);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? x - y : x + y;
            3'd1: r = x << y[4:0];
            3'd2: r = {31'd0, $signed(x) < $signed(y)};
            3'd3: r = {31'd0, x < y};
            3'd4: r = x ^ y;
            3'd5: begin
                if (alt)
                    r = $signed(x) >>> y[4:0];
                else
                    r = x >> y[4:0];
            end
            3'd6: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    function automatic exp_t model(input logic [31:0] ins, pc_v, a, b);
        exp_t        e;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i, imm_u, imm_b, imm_j;
        logic        ill, is_br;
        e     = '0;
        f3    = ins[14:12];
        f7    = ins[31:25];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'h000};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        e.rd  = ins[11:7];
        ill   = 1'b0;
        is_br = 1'b0;
        case (ins[6:0])
            exec_pkg::OPC_OP: begin
                ill    = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                e.data = alu_ref(f3, f7[5], a, b);
            end
            exec_pkg::OPC_OP_IMM: begin  // shamt forms constrain funct7
                ill    = (f3 == 3'd1 && f7 != 7'h00)
                      || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                e.data = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
            end
            exec_pkg::OPC_LUI:   e.data = imm_u;
            exec_pkg::OPC_AUIPC: e.data = pc_v + imm_u;
            exec_pkg::OPC_JAL: begin
                e.data   = pc_v + 32'd4;
                e.taken  = 1'b1;
                e.target = pc_v + imm_j;
            end
            exec_pkg::OPC_JALR: begin
                ill      = (f3 != 3'd0);
                e.data   = pc_v + 32'd4;
                e.taken  = 1'b1;
                e.target = (a + imm_i) & ~32'd1;
            end
            exec_pkg::OPC_BRANCH: begin
                is_br    = 1'b1;
                e.target = pc_v + imm_b;
                case (f3)
                    3'd0: e.taken = (a == b);
                    3'd1: e.taken = (a != b);
                    3'd4: e.taken = ($signed(a) < $signed(b));
                    3'd5: e.taken = ($signed(a) >= $signed(b));
                    3'd6: e.taken = (a < b);
                    3'd7: e.taken = (a >= b);
                    default: ill = 1'b1;
                endcase
            end
            default: ill = 1'b1;
        endcase
        e.illegal = ill;
        e.we      = !ill && !is_br && (e.rd != 5'd0);
        if (ill)
            e.taken = 1'b0;
        return e;
    endfunction

    // encoders, register indices are don't care here
    function automatic logic [31:0] r_instr(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, exec_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_instr(input logic [11:0] imm, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_instr(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_instr(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], exec_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_instr(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, exec_pkg::OPC_JAL};
    endfunction

    // random but legal, rd in x0..x3 so x0 shows up often
    function automatic logic [31:0] rand_instr();
        logic [31:0] ins;
        logic [2:0]  kind;
        ins       = $urandom;
        kind      = 3'($urandom % 6);
        ins[11:9] = 3'b000;
        case (kind)
            3'd0: begin
                ins[31:25] = ((ins[14:12] == 3'd0 || ins[14:12] == 3'd5) && ins[30])
                           ? 7'h20 : 7'h00;
                ins[6:0]   = exec_pkg::OPC_OP;
            end
            3'd1: begin
                if (ins[14:12] == 3'd1)
                    ins[31:25] = 7'h00;
                else if (ins[14:12] == 3'd5)
                    ins[31:25] = {1'b0, ins[30], 5'b0};  // srli or srai
                ins[6:0] = exec_pkg::OPC_OP_IMM;
            end
            3'd2: ins[6:0] = exec_pkg::OPC_LUI;
            3'd3: ins[6:0] = exec_pkg::OPC_AUIPC;
            3'd4: begin
                ins[6:0]   = ins[20] ? exec_pkg::OPC_JAL : exec_pkg::OPC_JALR;
                ins[14:12] = 3'd0;
            end
            default: begin
                if (ins[14:13] == 2'b01)
                    ins[14] = 1'b1;  // f3 2,3 -> 6,7
                ins[6:0] = exec_pkg::OPC_BRANCH;
            end
        endcase
        return ins;
    endfunction

    // one instruction per call, on the falling edge
    task automatic issue(input string name, input logic [31:0] ins, pc_v, a, b);
        instr_valid = 1'b1;
        instr       = ins;
        pc          = pc_v;
        rs1_data    = a;
        rs2_data    = b;
        exp_q.push_back(model(ins, pc_v, a, b));
        name_q.push_back(name);
        @(negedge clk);
    endtask

    task automatic drain(input string name);
        int cnt;
        instr_valid = 1'b0;
        cnt         = 0;
        while (exp_q.size() != 0 && cnt < 20) begin
            @(negedge clk);
            cnt++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: timed out, %0d results never came out", name, exp_q.size());
            exp_q.delete();
            name_q.delete();
        end
    endtask

    task automatic apply_reset();
        rst         = 1'b1;
        instr_valid = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
    endtask

    // reset lands while ins sits in the decode register, so writeback must drop it
    task automatic reset_in_flight(input string name, input logic [31:0] ins);
        issue(name, ins, 32'h0, 32'h0, 32'h0);
        rst         = 1'b1;
        instr_valid = 1'b0;
        @(negedge clk);
        exp_q.delete();
        name_q.delete();
        check_flag({name, " out_valid"}, 1'b0, out_valid);
        check_flag({name, " rd_we"}, 1'b0, rd_we);
        check_flag({name, " br_taken"}, 1'b0, br_taken);
        check_flag({name, " illegal"}, 1'b0, illegal);
        @(negedge clk);
        rst = 1'b0;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        exp_t  e;
        string nm;
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_valid came up with no instruction in flight");
            end else begin
                e  = exp_q.pop_front();
                nm = name_q.pop_front();
                check_flag({nm, " illegal"}, e.illegal, illegal);
                check_flag({nm, " rd_we"}, e.we, rd_we);
                check_flag({nm, " br_taken"}, e.taken, br_taken);
                if (e.we) begin
                    check_addr({nm, " rd_addr"}, e.rd, rd_addr);
                    check_data({nm, " rd_data"}, e.data, rd_data);
                end
                if (e.taken)
                    check_data({nm, " br_target"}, e.target, br_target);
            end
        end
    end

    task automatic reg_alu_ops();
        logic [3:0] fns [10];
        fns = '{4'h0, 4'h8, 4'h1, 4'h5, 4'hd, 4'h4, 4'h6, 4'h7, 4'h2, 4'h3};  // {f7[5], f3}
        for (int i = 0; i < 10; i++)
            issue($sformatf("reg_fn_%h", fns[i]), r_instr({1'b0, fns[i][3], 5'b0}, fns[i][2:0],
                  5'(i + 1)), $urandom, $urandom, $urandom);
        issue("slt_edge", r_instr(7'h00, 3'd2, 5'd11), 32'h0, 32'h8000_0000, 32'h1);
        issue("sltu_edge", r_instr(7'h00, 3'd3, 5'd12), 32'h0, 32'h8000_0000, 32'h1);
        drain("reg_alu_ops");
    endtask

    task automatic imm_and_upper_ops();
        issue("addi_neg", i_instr(12'hfff, 3'd0, 5'd3, exec_pkg::OPC_OP_IMM), 32'h0, 32'd10, 32'h0);
        issue("addi_min", i_instr(12'h800, 3'd0, 5'd4, exec_pkg::OPC_OP_IMM), 32'h0, 32'h0, 32'h0);
        issue("slti", i_instr(12'hffe, 3'd2, 5'd5, exec_pkg::OPC_OP_IMM), 32'h0, 32'hffff_fff0, 32'h0);
        issue("sltiu", i_instr(12'hfff, 3'd3, 5'd6, exec_pkg::OPC_OP_IMM), 32'h0, 32'd5, 32'h0);
        issue("xori", i_instr(12'h5a5, 3'd4, 5'd7, exec_pkg::OPC_OP_IMM), 32'h0, $urandom, 32'h0);
        issue("slli", i_instr({7'h00, 5'd31}, 3'd1, 5'd8, exec_pkg::OPC_OP_IMM),
              32'h0, $urandom, 32'h0);
        issue("srli", i_instr({7'h00, 5'd17}, 3'd5, 5'd9, exec_pkg::OPC_OP_IMM),
              32'h0, $urandom, 32'h0);
        issue("srai", i_instr({7'h20, 5'd7}, 3'd5, 5'd10, exec_pkg::OPC_OP_IMM),
              32'h0, 32'h8000_1234, 32'h0);
        issue("lui", u_instr(20'habcde, 5'd11, exec_pkg::OPC_LUI), $urandom, $urandom, 32'h0);
        issue("auipc", u_instr(20'h80001, 5'd12, exec_pkg::OPC_AUIPC), 32'h0000_1000, 32'h0, 32'h0);
        drain("imm_and_upper_ops");
    endtask

    task automatic cond_branches();
        logic [31:0] va [6];
        logic [31:0] vb [6];
        logic [2:0]  conds [6];
        logic [12:0] off;
        va    = '{32'd5, 32'd1, 32'd2, 32'h8000_0000, 32'd1, 32'hffff_ffff};
        vb    = '{32'd5, 32'd2, 32'd1, 32'd1, 32'h8000_0000, 32'd0};
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        foreach (conds[c])
            foreach (va[v]) begin
                off    = 13'($urandom);
                off[0] = 1'b0;
                issue($sformatf("branch_f3_%0d", conds[c]), b_instr(off, conds[c]),
                      $urandom, va[v], vb[v]);
            end
        drain("cond_branches");
    endtask

    task automatic jumps();
        issue("jal_back", j_instr(21'h1f_fff0, 5'd1), 32'h0000_2000, $urandom, $urandom);
        issue("jal_fwd", j_instr(21'h00_0800, 5'd2), 32'h0000_0100, $urandom, $urandom);
        issue("jalr_odd", i_instr(12'h100, 3'd0, 5'd3, exec_pkg::OPC_JALR), 32'h4000, 32'h1001, 32'h0);
        issue("jalr_x0", i_instr(12'hff9, 3'd0, 5'd0, exec_pkg::OPC_JALR), 32'h10, 32'h2000, 32'h0);
        drain("jumps");
    endtask

    task automatic b2b_stream();
        repeat (40) issue("stream", rand_instr(), $urandom, $urandom, $urandom);
        drain("b2b_stream");
    endtask

    task automatic illegal_and_reset();
        issue("load", i_instr(12'h004, 3'd2, 5'd5, 7'b0000011), 32'h0, $urandom, $urandom);
        issue("store", {7'h00, 5'd2, 5'd1, 3'd2, 5'd4, 7'b0100011}, 32'h0, $urandom, $urandom);
        issue("ecall", 32'h0000_0073, 32'h0, $urandom, $urandom);
        issue("mul", r_instr(7'h01, 3'd0, 5'd6), 32'h0, $urandom, $urandom);
        issue("sub_f3", r_instr(7'h20, 3'd1, 5'd7), 32'h0, $urandom, $urandom);
        issue("slli_f7", i_instr({7'h20, 5'd3}, 3'd1, 5'd8, exec_pkg::OPC_OP_IMM),
              32'h0, 32'h1, 32'h0);
        issue("branch_f3", b_instr(13'h010, 3'd2), 32'h0, 32'h1, 32'h1);
        issue("jalr_f3", i_instr(12'h000, 3'd1, 5'd9, exec_pkg::OPC_JALR), 32'h0, 32'h0, 32'h0);
        drain("illegal");
        // jal would raise rd_we and br_taken, the load would raise illegal
        reset_in_flight("reset_jal", j_instr(21'h00_0040, 5'd10));
        reset_in_flight("reset_load", i_instr(12'h004, 3'd2, 5'd5, 7'b0000011));
    endtask

    initial begin
        void'($urandom(43946));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        apply_reset();
        reg_alu_ops();
        imm_and_upper_ops();
        cond_branches();
        jumps();
        b2b_stream();
        illegal_and_reset();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* filelist.f */
source/exec_pkg.sv
source/exec_if.sv
source/exec_decode.sv
source/exec_alu.sv
source/exec_branch.sv
source/exec_writeback.sv
source/exec_top.sv
dv/exec_sva.sv
dv/exec_tb.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module exec_tb -f filelist.f \
    && ./obj_dir/Vexec_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

/* source/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
    exec_op_if.dst      op,
    exec_res_if.alu_src res
);

    logic                       sub_op;
    logic [exec_pkg::XLEN-1:0]  b_adder;        // b, inverted on sub
    logic [exec_pkg::XLEN-1:0]  adder_result;

    logic                       sll_op, sra_op;
    logic [4:0]                 shift_amt;      // low five bits of b
    logic [exec_pkg::XLEN-1:0]  a_reversed;
    logic [exec_pkg::XLEN-1:0]  shift_in;
    logic [exec_pkg::XLEN-1:0]  shift_l;        // logical right
    logic [exec_pkg::XLEN-1:0]  shift_a;        // arithmetic right
    logic [exec_pkg::XLEN-1:0]  shift_reversed;
    logic [exec_pkg::XLEN-1:0]  shifter_result;

    logic                       lt_s, lt_u;
    logic [exec_pkg::XLEN-1:0]  result;

    // shared adder, sub = a + ~b + 1
    always_comb begin
        sub_op       = (op.alu_fn == exec_pkg::ALU_SUB);
        b_adder      = op.operand_b ^ {exec_pkg::XLEN{sub_op}};
        adder_result = op.operand_a + b_adder + {{(exec_pkg::XLEN-1){1'b0}}, sub_op};
    end

    // one right shifter, sll by reversing in and out
    always_comb begin
        sll_op         = (op.alu_fn == exec_pkg::ALU_SLL);
        sra_op         = (op.alu_fn == exec_pkg::ALU_SRA);
        shift_amt      = op.operand_b[4:0];
        a_reversed     = {<<{op.operand_a}};
        shift_in       = sll_op ? a_reversed : op.operand_a;
        shift_l        = shift_in >> shift_amt;
        shift_a        = $signed(shift_in) >>> shift_amt;
        shift_reversed = {<<{shift_l}};
        if (sra_op)
            shifter_result = shift_a;
        else if (sll_op)
            shifter_result = shift_reversed;
        else
            shifter_result = shift_l;
    end

    // set-less-than compares
    assign lt_s = ($signed(op.operand_a) < $signed(op.operand_b));
    assign lt_u = (op.operand_a < op.operand_b);

    always_comb begin
        case (op.alu_fn)
            exec_pkg::ALU_ADD,
            exec_pkg::ALU_SUB:  result = adder_result;
            exec_pkg::ALU_SLL,
            exec_pkg::ALU_SRL,
            exec_pkg::ALU_SRA:  result = shifter_result;
            exec_pkg::ALU_XOR:  result = op.operand_a ^ op.operand_b;
            exec_pkg::ALU_OR:   result = op.operand_a | op.operand_b;
            exec_pkg::ALU_AND:  result = op.operand_a & op.operand_b;
            exec_pkg::ALU_SLT:  result = {{(exec_pkg::XLEN-1){1'b0}}, lt_s};
            exec_pkg::ALU_SLTU: result = {{(exec_pkg::XLEN-1){1'b0}}, lt_u};
            default:            result = '0;
        endcase
    end

    // pass-through of the instruction tags
    assign res.valid   = op.valid;
    assign res.result  = result;
    assign res.rd      = op.rd;
    assign res.rd_we   = op.rd_we;
    assign res.illegal = op.illegal;

endmodule

/* source/exec_branch.sv */
`timescale 1ns/1ps

module exec_branch (
    exec_op_if.dst     op,
    exec_res_if.br_src res
);

    logic                       eq, lt_s, lt_u;
    logic                       is_jalr;
    logic [exec_pkg::XLEN-1:0]  base;
    logic [exec_pkg::XLEN-1:0]  sum;

    // compares on rs1 / rs2
    assign eq   = (op.cmp_a == op.cmp_b);
    assign lt_s = ($signed(op.cmp_a) < $signed(op.cmp_b));
    assign lt_u = (op.cmp_a < op.cmp_b);

    always_comb begin
        case (op.br_kind)
            exec_pkg::BR_BEQ:  res.taken = eq;
            exec_pkg::BR_BNE:  res.taken = !eq;
            exec_pkg::BR_BLT:  res.taken = lt_s;
            exec_pkg::BR_BGE:  res.taken = !lt_s;
            exec_pkg::BR_BLTU: res.taken = lt_u;
            exec_pkg::BR_BGEU: res.taken = !lt_u;
            exec_pkg::BR_JAL,
            exec_pkg::BR_JALR: res.taken = 1'b1;  // unconditional
            default:           res.taken = 1'b0;  // BR_NONE
        endcase
    end

    // target adder
    assign is_jalr = (op.br_kind == exec_pkg::BR_JALR);
    assign base    = is_jalr ? op.cmp_a : op.pc;   // jalr is rs1 relative
    assign sum     = base + op.imm;

    // jalr drops bit 0
    assign res.target = is_jalr ? {sum[exec_pkg::XLEN-1:1], 1'b0} : sum;

endmodule

/* source/exec_decode.sv */
`timescale 1ns/1ps

module exec_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    input  logic [exec_pkg::XLEN-1:0] pc,
    input  logic [exec_pkg::XLEN-1:0] rs1_data,
    input  logic [exec_pkg::XLEN-1:0] rs2_data,
    exec_op_if.src                    op
);

    exec_pkg::opcode_e          opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [4:0]                 rd;
    logic [exec_pkg::XLEN-1:0]  imm_i, imm_u, imm_j, imm_b;

    exec_pkg::alu_fn_e          alu_fn_d;
    exec_pkg::br_kind_e         br_kind_d;
    logic [exec_pkg::XLEN-1:0]  imm_d;
    logic [exec_pkg::XLEN-1:0]  opa_d, opb_d;
    logic                       we_d, ill_d;

    // instruction fields
    assign opcode = exec_pkg::opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        alu_fn_d  = exec_pkg::ALU_ADD;
        br_kind_d = exec_pkg::BR_NONE;
        imm_d     = imm_i;
        opa_d     = rs1_data;   // default rs1 / rs2
        opb_d     = rs2_data;
        we_d      = 1'b1;
        ill_d     = 1'b0;
        case (opcode)
            exec_pkg::OPC_OP: begin
                alu_fn_d = exec_pkg::alu_fn_e'({funct7[5], funct3});
                if (funct7 == 7'b0100000)
                    ill_d = !(funct3 == 3'b000 || funct3 == 3'b101); // only sub, sra
                else
                    ill_d = (funct7 != 7'b0000000);
            end
            exec_pkg::OPC_OP_IMM: begin
                opb_d = imm_i;
                if (funct3 == 3'b001) begin
                    alu_fn_d = exec_pkg::ALU_SLL;
                    ill_d    = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    // srli / srai picked by funct7[5]
                    alu_fn_d = exec_pkg::alu_fn_e'({funct7[5], 3'b101});
                    ill_d    = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end else begin
                    alu_fn_d = exec_pkg::alu_fn_e'({1'b0, funct3}); // no subi
                end
            end
            exec_pkg::OPC_LUI: begin
                opa_d = '0;
                opb_d = imm_u;
                imm_d = imm_u;
            end
            exec_pkg::OPC_AUIPC: begin
                opa_d = pc;
                opb_d = imm_u;
                imm_d = imm_u;
            end
            exec_pkg::OPC_JAL: begin
                opa_d     = pc;     // link = pc + 4
                opb_d     = 32'd4;
                imm_d     = imm_j;
                br_kind_d = exec_pkg::BR_JAL;
            end
            exec_pkg::OPC_JALR: begin
                opa_d     = pc;
                opb_d     = 32'd4;
                br_kind_d = exec_pkg::BR_JALR;
                ill_d     = (funct3 != 3'b000);
            end
            exec_pkg::OPC_BRANCH: begin
                imm_d = imm_b;
                we_d  = 1'b0;       // branches never write rd
                case (funct3)
                    3'b000:  br_kind_d = exec_pkg::BR_BEQ;
                    3'b001:  br_kind_d = exec_pkg::BR_BNE;
                    3'b100:  br_kind_d = exec_pkg::BR_BLT;
                    3'b101:  br_kind_d = exec_pkg::BR_BGE;
                    3'b110:  br_kind_d = exec_pkg::BR_BLTU;
                    3'b111:  br_kind_d = exec_pkg::BR_BGEU;
                    default: ill_d = 1'b1;
                endcase
            end
            default: ill_d = 1'b1; // loads, stores, fence, system
        endcase
        if (ill_d) begin
            alu_fn_d  = exec_pkg::ALU_ADD;
            br_kind_d = exec_pkg::BR_NONE;
            we_d      = 1'b0;
        end
        if (rd == 5'd0)
            we_d = 1'b0;    // x0 is hardwired zero
    end

    // control fields, qualified by instr_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            op.valid   <= 1'b0;
            op.rd_we   <= 1'b0;
            op.illegal <= 1'b0;
            op.br_kind <= exec_pkg::BR_NONE;
        end else begin
            op.valid   <= instr_valid;
            op.rd_we   <= instr_valid & we_d;
            op.illegal <= instr_valid & ill_d;
            op.br_kind <= instr_valid ? br_kind_d : exec_pkg::BR_NONE;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        op.alu_fn    <= alu_fn_d;
        op.operand_a <= opa_d;
        op.operand_b <= opb_d;
        op.cmp_a     <= rs1_data;
        op.cmp_b     <= rs2_data;
        op.pc        <= pc;
        op.imm       <= imm_d;
        op.rd        <= rd;
    end

endmodule

/* source/exec_if.sv */
`timescale 1ns/1ps

// registered decode results, decode -> alu and branch
interface exec_op_if;
    logic                         valid;
    exec_pkg::alu_fn_e            alu_fn;
    logic [exec_pkg::XLEN-1:0]    operand_a;
    logic [exec_pkg::XLEN-1:0]    operand_b;
    exec_pkg::br_kind_e           br_kind;
    logic [exec_pkg::XLEN-1:0]    cmp_a;     // rs1
    logic [exec_pkg::XLEN-1:0]    cmp_b;     // rs2
    logic [exec_pkg::XLEN-1:0]    pc;
    logic [exec_pkg::XLEN-1:0]    imm;
    logic [4:0]                   rd;
    logic                         rd_we;
    logic                         illegal;

    modport src (output valid, alu_fn, operand_a, operand_b, br_kind, cmp_a, cmp_b,
                 pc, imm, rd, rd_we, illegal);
    modport dst (input valid, alu_fn, operand_a, operand_b, br_kind, cmp_a, cmp_b,
                 pc, imm, rd, rd_we, illegal);
endinterface

// combinational execute results, alu and branch -> writeback
interface exec_res_if;
    logic                         valid;
    logic [exec_pkg::XLEN-1:0]    result;
    logic [4:0]                   rd;
    logic                         rd_we;
    logic                         illegal;
    logic                         taken;    // from branch unit
    logic [exec_pkg::XLEN-1:0]    target;   // from branch unit

    modport alu_src (output valid, result, rd, rd_we, illegal);
    modport br_src  (output taken, target);
    modport dst     (input valid, result, rd, rd_we, illegal, taken, target);
endinterface

/* source/exec_pkg.sv */
package exec_pkg;

    localparam int XLEN = 32; // rv32i word width

    // major opcodes handled by this stage
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // alu function, {funct7[5], funct3} layout
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SRA  = 4'b1101
    } alu_fn_e;

    typedef enum logic [3:0] {
        BR_NONE, // not a control transfer
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR  // target from rs1
    } br_kind_e;

endpackage

/* source/exec_top.sv */
`timescale 1ns/1ps

module exec_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instr_valid,
    input  logic [31:0]                instr,
    input  logic [exec_pkg::XLEN-1:0]  pc,
    input  logic [exec_pkg::XLEN-1:0]  rs1_data,
    input  logic [exec_pkg::XLEN-1:0]  rs2_data,
    output logic                       out_valid,
    output logic [4:0]                 rd_addr,
    output logic                       rd_we,
    output logic [exec_pkg::XLEN-1:0]  rd_data,
    output logic                       br_taken,
    output logic [exec_pkg::XLEN-1:0]  br_target,
    output logic                       illegal
);

    exec_op_if  op_bus ();   // after decode register
    exec_res_if res_bus ();  // before writeback register

    exec_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .op          (op_bus.src)
    );

    exec_alu u_alu (
        .op  (op_bus.dst),
        .res (res_bus.alu_src)
    );

    exec_branch u_branch (
        .op  (op_bus.dst),
        .res (res_bus.br_src)
    );

    exec_writeback u_writeback (
        .clk       (clk),
        .rst       (rst),
        .res       (res_bus.dst),
        .out_valid (out_valid),
        .rd_addr   (rd_addr),
        .rd_we     (rd_we),
        .rd_data   (rd_data),
        .br_taken  (br_taken),
        .br_target (br_target),
        .illegal   (illegal)
    );

endmodule

/* source/exec_writeback.sv */
`timescale 1ns/1ps

module exec_writeback (
    input  logic                       clk,
    input  logic                       rst,
    exec_res_if.dst                    res,
    output logic                       out_valid,
    output logic [4:0]                 rd_addr,
    output logic                       rd_we,
    output logic [exec_pkg::XLEN-1:0]  rd_data,
    output logic                       br_taken,
    output logic [exec_pkg::XLEN-1:0]  br_target,
    output logic                       illegal
);

    // strobes, low whenever no instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            rd_we     <= 1'b0;
            br_taken  <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= res.valid;
            rd_we     <= res.valid & res.rd_we;
            br_taken  <= res.valid & res.taken;
            illegal   <= res.valid & res.illegal;
        end
    end

    // data held between instructions
    always_ff @(posedge clk) begin
        if (res.valid) begin
            rd_addr   <= res.rd;
            rd_data   <= res.result;
            br_target <= res.target;
        end
    end

endmodule
